// File: test/burst_arbiter_patterns.txt
// valid last data0 data1 data2 data3 grant, all hex, one clock cycle per line
// bit i of valid, last and grant is source i, dataN is the word source N presents
f f 0a00 1a00 2a00 3a00 1
f f 0a01 1a00 2a00 3a00 2
f f 0a01 1a01 2a00 3a00 4
f f 0a01 1a01 2a01 3a00 8
f f 0a01 1a01 2a01 3a01 1
9 9 0b00 1a01 2a01 3b00 8
1 1 0b00 1a01 2a01 3b00 1
5 5 0b01 1a01 2b00 3b00 4
3 3 0b01 1b00 2b00 3b00 1
2 2 0b01 1b00 2b00 3b00 2
f b 0c00 1c00 2c00 3c00 4
f b 0c00 1c00 2c01 3c00 4
f f 0c00 1c00 2c02 3c00 4
b b 0c00 1c00 2c02 3c00 8
3 3 0c00 1c00 2c02 3c01 1
2 2 0c01 1c00 2c02 3c01 2
c 8 0d00 1d00 2d00 3d00 4
c 8 0d00 1d00 2d01 3d00 4
c 8 0d00 1d00 2d02 3d00 4
c 8 0d00 1d00 2d03 3d00 4
c 8 0d00 1d00 2d04 3d00 8
4 0 0d00 1d00 2d04 3d01 4
4 0 0d00 1d00 2d05 3d01 4
0 0 0000 0000 0000 0000 0

// File: all.f
+incdir+include
design/arb_pkg.sv
design/burst_pkg.sv
design/arb_rr.sv
design/arb_hold_rr.sv
design/burst_merge.sv
design/burst_arbiter_top.sv
test/burst_arbiter_tb.sv

// File: run.sh
#!/bin/sh
# Build the burst arbiter testbench with Verilator and run it
# The run counts as passed only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module burst_arbiter_tb \
  -f all.f -o sim_burst_arbiter || { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/sim_burst_arbiter)"
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation passed" && exit 0 || exit 1

// File: test/burst_arbiter_tb.sv
/* Burst arbiter testbench */
`timescale 1ns/10ps
`default_nettype none

`include "arb_settings.svh"

module burst_arbiter_tb
  import arb_pkg::*, burst_pkg::*;
();

  // ------------------------------------------------------------
  // Run constants
  // ------------------------------------------------------------

  localparam int    CLK_PERIOD    = 4;
  localparam int    RESET_CYCLES  = 3;
  localparam int    RANDOM_CYCLES = 400;
  localparam int    SLACK_CYCLES  = 20;
  localparam int    DRIVE_DELAY   = 1;
  // Outputs settle well before the next rising edge
  localparam int    SAMPLE_DELAY  = 2;
  localparam int    SEED          = 32'hcf7f2358;
  localparam string PATTERN_FILE  = "test/burst_arbiter_patterns.txt";

  logic                         clk = 1'b0;
  logic                         rst_n;
  req_vec_t                     valid;
  req_vec_t                     last;
  data_t    [`ARB_NUM_REQ-1:0]  data;
  req_vec_t                     grant;
  logic                         out_valid;
  data_t                        out_data;
  req_idx_t                     out_src;
  beat_t                        out_beat;
  logic                         out_last;

  // Pattern table, one entry per clock cycle
  req_vec_t                     pat_valid[$];
  req_vec_t                     pat_last[$];
  req_vec_t                     pat_grant[$];
  data_t    [`ARB_NUM_REQ-1:0]  pat_data[$];
  logic                         patterns_loaded = 1'b0;
  int                           seed;

  int grant_errors = 0;
  int data_errors  = 0;
  int src_errors   = 0;
  int beat_errors  = 0;
  int bit_errors   = 0;
  int other_errors = 0;

  // Reference model state, the pointer starts at source 0
  int       m_ptr      = 0;
  logic     m_open     = 1'b0;
  req_idx_t m_open_idx = '0;
  int       m_beat     = 0;
  // Output expected one clock after the modelled grant
  logic     exp_valid  = 1'b0;
  logic     exp_last   = 1'b0;
  beat_t    exp_beat   = '0;
  data_t    exp_data   = '0;
  req_idx_t exp_src    = '0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  burst_arbiter_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .last      (last),
    .data      (data),
    .grant     (grant),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_src   (out_src),
    .out_beat  (out_beat),
    .out_last  (out_last)
  );

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_grant(input string name, input req_vec_t exp, input req_vec_t act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      grant_errors++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      data_errors++;
    end
  endtask

  task automatic check_src(input string name, input req_idx_t exp, input req_idx_t act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      src_errors++;
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      beat_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
      bit_errors++;
    end
  endtask

  // Grant must be one-hot or zero and only go to a valid source
  task automatic check_grant_rules();
    if (!$onehot0(grant)) begin
      $display("Grant has more than one bit set at %0t", $time);
      other_errors++;
    end
    if ((grant & ~valid) != '0) begin
      $display("Grant given to a source without valid at %0t", $time);
      other_errors++;
    end
  endtask

  // The registered outputs carry the word granted one cycle earlier
  task automatic check_outputs();
    check_bit("out_valid", exp_valid, out_valid);
    check_bit("out_last", exp_last, out_last);
    check_beat("out_beat", exp_beat, out_beat);
    if (exp_valid) begin
      check_data("out_data", exp_data, out_data);
      check_src("out_src", exp_src, out_src);
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // An open burst keeps the channel while its source stays valid
  // Otherwise the first valid source from the pointer onward wins
  task automatic model_step(input req_vec_t v, input req_vec_t l,
                            input data_t [`ARB_NUM_REQ-1:0] d, output req_vec_t g);
    req_idx_t sel;
    req_idx_t win;
    logic     found;
    logic     ends;
    int       beat;
    g     = '0;
    win   = '0;
    found = 1'b0;
    beat  = 0;
    if (m_open && v[m_open_idx]) begin
      found = 1'b1;
      win   = m_open_idx;
      beat  = m_beat;
    end else begin
      for (int k = 0; k < `ARB_NUM_REQ; k++) begin
        sel = req_idx_t'((m_ptr + k) % `ARB_NUM_REQ);
        if (!found && v[sel]) begin
          found = 1'b1;
          win   = sel;
        end
      end
      if (found) begin
        m_ptr = (int'(win) + 1) % `ARB_NUM_REQ;
      end
    end
    if (found) begin
      ends      = l[win] || (beat == `ARB_MAX_BURST - 1);
      g[win]    = 1'b1;
      exp_valid = 1'b1;
      exp_last  = ends;
      exp_beat  = beat_t'(beat);
      exp_data  = d[win];
      exp_src   = win;
      m_open     = !ends;
      m_open_idx = win;
      m_beat     = ends ? 0 : beat + 1;
    end else begin
      exp_valid = 1'b0;
      exp_last  = 1'b0;
      exp_beat  = '0;
      m_open    = 1'b0;
      m_beat    = 0;
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  task automatic load_patterns();
    int                          fd;
    int                          n;
    string                       line;
    req_vec_t                    v;
    req_vec_t                    l;
    req_vec_t                    g;
    data_t                       d0;
    data_t                       d1;
    data_t                       d2;
    data_t                       d3;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PATTERN_FILE);
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Comment lines fail the scan and are skipped
        if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h", v, l, d0, d1, d2, d3, g) == 7) begin
          pat_valid.push_back(v);
          pat_last.push_back(l);
          pat_grant.push_back(g);
          pat_data.push_back({d3, d2, d1, d0});
        end
      end
      $fclose(fd);
      if (pat_valid.size() == 0) begin
        $display("The pattern file %s holds no patterns", PATTERN_FILE);
        other_errors++;
      end
    end
  endtask

  // One clock cycle: drive, check last cycle's output, then the grant
  task automatic run_cycle(input req_vec_t v, input req_vec_t l,
                           input data_t [`ARB_NUM_REQ-1:0] d, input logic from_file,
                           input req_vec_t file_grant, output req_vec_t model_g);
    @(posedge clk);
    #DRIVE_DELAY;
    valid = v;
    last  = l;
    data  = d;
    #SAMPLE_DELAY;
    check_outputs();
    model_step(v, l, d, model_g);
    check_grant("grant", from_file ? file_grant : model_g, grant);
    check_grant_rules();
  endtask

  task automatic finish_run();
    int total;
    total = grant_errors + data_errors + src_errors + beat_errors + bit_errors + other_errors;
    $display("Errors: grant %0d, data %0d, src %0d, beat %0d, flag %0d, other %0d",
             grant_errors, data_errors, src_errors, beat_errors, bit_errors, other_errors);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    req_vec_t                    g;
    req_vec_t                    rv;
    req_vec_t                    rl;
    data_t    [`ARB_NUM_REQ-1:0] rd;
    seed  = SEED;
    rst_n = 1'b0;
    valid = '0;
    last  = '0;
    data  = '0;
    load_patterns();
    patterns_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    #SAMPLE_DELAY;
    check_grant("grant", '0, grant);
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("out_last", 1'b0, out_last);

    // Directed replay of rotation, skip, hold and cap cases
    foreach (pat_valid[i]) begin
      run_cycle(pat_valid[i], pat_last[i], pat_data[i], 1'b1, pat_grant[i], g);
    end

    // Random traffic, a waiting source keeps its word until granted
    rv = '0;
    rl = '0;
    rd = '0;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      run_cycle(rv, rl, rd, 1'b0, '0, g);
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (g[i] || !rv[i]) begin
          rv[i] = ($unsigned($random(seed)) % 4) != 0;
          rl[i] = ($unsigned($random(seed)) % 3) == 0;
          rd[i] = data_t'($random(seed));
        end
      end
    end
    // Idle cycle so the final granted word reaches the output check
    run_cycle('0, '0, '0, 1'b0, '0, g);
    finish_run();
  end

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------

  initial begin
    int timeout_ns;
    wait (patterns_loaded);
    timeout_ns = (RESET_CYCLES + pat_valid.size() + RANDOM_CYCLES + SLACK_CYCLES) * CLK_PERIOD;
    #(timeout_ns);
    $display("Watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/burst_arbiter_top.sv
/* Burst arbiter top level */
`timescale 1ns/10ps
`default_nettype none

`include "arb_settings.svh"

module burst_arbiter_top
  import arb_pkg::*, burst_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  req_vec_t                     valid,
  input  req_vec_t                     last,
  input  data_t    [`ARB_NUM_REQ-1:0]  data,
  output req_vec_t                     grant,
  output logic                         out_valid,
  output data_t                        out_data,
  output req_idx_t                     out_src,
  output beat_t                        out_beat,
  output logic                         out_last
);

  // ------------------------------------------------------------
  // Hold loop between arbiter and data path
  // ------------------------------------------------------------

  // Driven by the merge stage, closes the loop back into the arbiter
  req_vec_t grant_hold;

  // Valid levels act directly as requests
  arb_hold_rr u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .request    (valid),
    .grant_hold (grant_hold),
    .grant      (grant)
  );

  // Registers the granted word one cycle after the grant
  burst_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant      (grant),
    .valid      (valid),
    .last       (last),
    .data       (data),
    .grant_hold (grant_hold),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_src    (out_src),
    .out_beat   (out_beat),
    .out_last   (out_last)
  );

endmodule

`default_nettype wire

// File: design/burst_merge.sv
/* Burst merge output stage */
`timescale 1ns/10ps
`default_nettype none

`include "arb_settings.svh"

module burst_merge
  import arb_pkg::*, burst_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  req_vec_t                     grant,
  input  req_vec_t                     valid,
  input  req_vec_t                     last,
  input  data_t    [`ARB_NUM_REQ-1:0]  data,
  output req_vec_t                     grant_hold,
  output logic                         out_valid,
  output data_t                        out_data,
  output req_idx_t                     out_src,
  output beat_t                        out_beat,
  output logic                         out_last
);

  // ------------------------------------------------------------
  // Grant decode
  // ------------------------------------------------------------

  req_idx_t src_idx;
  data_t    sel_data;
  logic     sel_last;
  logic     grant_any;

  // The grant is one-hot or zero, so a plain scan gives the index
  always_comb begin
    src_idx = '0;
    for (int k = 0; k < `ARB_NUM_REQ; k++) begin
      if (grant[k]) begin
        src_idx = req_idx_t'(k);
      end
    end
  end

  assign grant_any = |grant;
  assign sel_data  = data[src_idx];
  assign sel_last  = last[src_idx];

  // ------------------------------------------------------------
  // Beat tracking
  // ------------------------------------------------------------

  // Beat number the next word of an open burst will carry
  beat_t    beat_cnt;
  // Beat number of the word granted this cycle
  beat_t    cur_beat;
  // Granted source whose burst is still open, at most one bit set
  req_vec_t burst_open;
  logic     cont;
  logic     end_burst;

  // A grant to the source with an open burst continues that burst
  // Any other grant starts a fresh one at beat 0
  assign cont      = |(grant & grant_hold);
  assign cur_beat  = cont ? beat_cnt : '0;
  // The burst closes on its last flag or when it hits the cap
  assign end_burst = sel_last || (cur_beat == beat_t'(`ARB_MAX_BURST - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt   <= '0;
      burst_open <= '0;
    end else if (grant_any && !end_burst) begin
      beat_cnt   <= cur_beat + beat_t'(1);
      burst_open <= grant;
    end else begin
      beat_cnt   <= '0;
      burst_open <= '0;
    end
  end

  // Keep the grant on the open burst while its next word is present
  // A source that drops valid mid-burst loses the channel
  assign grant_hold = valid & burst_open;

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_beat  <= '0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= grant_any;
      out_beat  <= cur_beat;
      out_last  <= grant_any && end_burst;
    end
  end

  // Payload only loads on a grant
  always_ff @(posedge clk) begin
    if (grant_any) begin
      out_data <= sel_data;
      out_src  <= src_idx;
    end
  end

  // The hold loop through the arbiter must respect the cap
  a_beat_in_range : assert property (@(posedge clk) disable iff (!rst_n)
    out_beat <= beat_t'(`ARB_MAX_BURST - 1));

  // the final beat of a capped burst is always flagged
  a_cap_is_last : assert property (@(posedge clk) disable iff (!rst_n)
    (out_beat == beat_t'(`ARB_MAX_BURST - 1)) |-> out_last);

endmodule

`default_nettype wire

// File: design/arb_hold_rr.sv
/* Round-robin arbiter with grant hold */
`timescale 1ns/10ps
`default_nettype none

module arb_hold_rr
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  req_vec_t request,
  input  req_vec_t grant_hold,
  output req_vec_t grant
);

  // ------------------------------------------------------------
  // Core arbiter
  // ------------------------------------------------------------

  logic     enable_priority_update;
  req_vec_t grant_pre;
  // Grant given in the previous cycle
  req_vec_t grant_last;
  // Source that keeps the grant this cycle, zero when nobody holds
  req_vec_t hold;

  arb_rr u_arb_rr (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .grant                  (grant_pre)
  );

  // ------------------------------------------------------------
  // Hold logic
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_last <= '0;
    end else begin
      grant_last <= grant;
    end
  end

  // A hold bit only counts for the source that won last cycle
  assign hold = grant_hold & grant_last;

  // The pointer stays put while a burst owns the channel
  assign enable_priority_update = ~|hold;

  // The grant follows grant_hold combinationally
  assign grant = |hold ? hold : grant_pre;

  // A multi-hot grant_hold still yields a single held source
  a_hold_onehot0 : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(hold));

endmodule

`default_nettype wire

// File: design/arb_rr.sv
/* Round-robin arbiter core */
`timescale 1ns/10ps
`default_nettype none

`include "arb_settings.svh"

module arb_rr
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable_priority_update,
  input  req_vec_t request,
  output req_vec_t grant
);

  // ------------------------------------------------------------
  // Priority pointer
  // ------------------------------------------------------------

  // Source holding the highest priority in the current cycle
  req_idx_t ptr_q;
  // Winner of this cycle, only meaningful while grant_any is set
  req_idx_t grant_idx;
  // Pointer value for the cycle after a grant
  req_idx_t ptr_nxt;
  logic     grant_any;

  // ------------------------------------------------------------
  // Grant selection
  // ------------------------------------------------------------

  // Walk the sources starting at the pointer and wrapping around
  // The first requester met on the way wins
  always_comb begin
    req_idx_t cand;
    logic     found;
    grant     = '0;
    grant_idx = ptr_q;
    found     = 1'b0;
    cand      = ptr_q;
    for (int k = 0; k < `ARB_NUM_REQ; k++) begin
      cand = req_idx_t'((int'(ptr_q) + k) % `ARB_NUM_REQ);
      if (!found && request[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
    // At most one bit is set here, the grant is one-hot or zero
    if (found) begin
      grant[grant_idx] = 1'b1;
    end
  end

  assign grant_any = |grant;

  // The granted source drops to lowest priority next cycle
  // Its upper neighbour, modulo the source count, becomes highest
  assign ptr_nxt = req_idx_t'((int'(grant_idx) + 1) % `ARB_NUM_REQ);

  // ------------------------------------------------------------
  // Pointer register
  // ------------------------------------------------------------

  // Source 0 starts with the highest priority
  // The pointer only moves on a real grant, and the hold wrapper
  // freezes it for the length of a held burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (enable_priority_update && grant_any) begin
      ptr_q <= ptr_nxt;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Never more than one winner per cycle
  a_grant_onehot0 : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant));

  // A source that is not requesting is never granted
  a_grant_in_request : assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~request) == '0);

endmodule

`default_nettype wire

// File: design/burst_pkg.sv
/* Burst data path types */
`default_nettype none

`include "arb_settings.svh"

package burst_pkg;

  // ------------------------------------------------------------
  // Payload
  // ------------------------------------------------------------

  // One word as presented by a source and driven on the output
  typedef logic [`ARB_DATA_W-1:0] data_t;

  // ------------------------------------------------------------
  // Burst bookkeeping
  // ------------------------------------------------------------

  // Position of a word inside its burst, the first word is beat 0
  typedef logic [`ARB_BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

// File: design/arb_pkg.sv
/* Arbitration types */
`default_nettype none

`include "arb_settings.svh"

package arb_pkg;

  // ------------------------------------------------------------
  // Per-source vectors
  // ------------------------------------------------------------

  // One bit per source
  // Used for request, grant, grant_hold and the last flags
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // ------------------------------------------------------------
  // Source numbering
  // ------------------------------------------------------------

  // Index of a single source, also the width of the priority pointer
  typedef logic [$clog2(`ARB_NUM_REQ)-1:0] req_idx_t;

endpackage

`default_nettype wire

// File: include/arb_settings.svh
/* Burst arbiter build settings */

`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// ------------------------------------------------------------
// Sizes shared by the packages and the RTL
// ------------------------------------------------------------

// Number of sources competing for the output channel
`define ARB_NUM_REQ 4

// Width of one data word carried by a source
`define ARB_DATA_W 16

// Longest burst that may keep the grant, counted in words
`define ARB_MAX_BURST 4

// Beat counter width, enough to count 0 .. ARB_MAX_BURST-1
`define ARB_BEAT_W 2

`endif
